/* logic/core_pkg.sv */
// core_pkg: word and register types, opcode and control enums, decode and retire structs
package core_pkg;

  typedef logic [31:0] word;
  typedef logic [4:0] reg_idx;

  // defaults handed down by the top level
  localparam int QUEUE_DEPTH_DEF = 4;
  localparam int RETIRE_CREDITS_DEF = 2;
  localparam int DMEM_WORDS_DEF = 64;
  localparam word RESET_PC_DEF = 32'h0000_0000;

  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LUI    = 7'b0110111,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  typedef enum logic [1:0] {
    BR_BEQ,
    BR_BNE,
    BR_BLT
  } branch_op_t;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC_PLUS_4
  } wb_sel_t;

  typedef struct packed {
    reg_idx     rs1;
    reg_idx     rs2;
    reg_idx     rd;
    word        imm;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       zero_a;
    logic       is_branch;
    branch_op_t branch_op;
    logic       is_jump;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    wb_sel_t    wb_sel;
    logic       illegal;
  } decoded_t;

  typedef struct packed {
    word    pc;
    reg_idx rd;
    word    data;
    logic   reg_write;
    logic   illegal;
  } retire_rec_t;

endpackage

/* logic/instr_queue.sv */
// instr_queue: circular instruction buffer with credit return
`timescale 1ns/1ps

module instr_queue #(
  parameter int QUEUE_DEPTH = core_pkg::QUEUE_DEPTH_DEF
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         instr_valid,
  input  core_pkg::word instr,
  input  logic         pop,
  output logic         head_valid,
  output core_pkg::word head,
  output logic         instr_credit
);
  import core_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  word buffer [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic push;
  logic do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push = instr_valid;
  assign do_pop = pop && head_valid;
  assign head_valid = (count != '0);
  assign head = buffer[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      buffer[wr_ptr] <= instr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      instr_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      // one credit back per removed entry
      instr_credit <= do_pop;
    end
  end

endmodule

/* logic/decode_unit.sv */
// decode_unit: RV32I subset decoder with immediate generation and illegal detection
`timescale 1ns/1ps

module decode_unit (
  input  logic              head_valid,
  input  core_pkg::word     instr,
  output logic              issue_valid,
  output core_pkg::decoded_t decoded
);
  import core_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  word imm_i;
  word imm_s;
  word imm_b;
  word imm_u;
  word imm_j;

  assign issue_valid = head_valid;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    decoded = '0;
    decoded.rs1 = instr[19:15];
    decoded.rs2 = instr[24:20];
    decoded.rd = instr[11:7];
    decoded.alu_op = ALU_ADD;
    decoded.branch_op = BR_BEQ;
    decoded.wb_sel = WB_ALU;

    case (instr[6:0])
      OP_REG: begin
        decoded.reg_write = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: decoded.alu_op = ALU_ADD;
          10'b0100000_000: decoded.alu_op = ALU_SUB;
          10'b0000000_111: decoded.alu_op = ALU_AND;
          10'b0000000_110: decoded.alu_op = ALU_OR;
          10'b0000000_100: decoded.alu_op = ALU_XOR;
          10'b0000000_010: decoded.alu_op = ALU_SLT;
          default: decoded.illegal = 1'b1;
        endcase
      end
      OP_IMM: begin
        // only ADDI
        decoded.illegal = (funct3 != 3'b000);
        decoded.use_imm = 1'b1;
        decoded.imm = imm_i;
        decoded.reg_write = 1'b1;
      end
      OP_LUI: begin
        decoded.zero_a = 1'b1;
        decoded.use_imm = 1'b1;
        decoded.imm = imm_u;
        decoded.reg_write = 1'b1;
      end
      OP_LOAD: begin
        decoded.illegal = (funct3 != 3'b010);
        decoded.use_imm = 1'b1;
        decoded.imm = imm_i;
        decoded.mem_read = 1'b1;
        decoded.reg_write = 1'b1;
        decoded.wb_sel = WB_MEM;
      end
      OP_STORE: begin
        decoded.illegal = (funct3 != 3'b010);
        decoded.use_imm = 1'b1;
        decoded.imm = imm_s;
        decoded.mem_write = 1'b1;
      end
      OP_BRANCH: begin
        decoded.imm = imm_b;
        decoded.is_branch = 1'b1;
        case (funct3)
          3'b000: decoded.branch_op = BR_BEQ;
          3'b001: decoded.branch_op = BR_BNE;
          3'b100: decoded.branch_op = BR_BLT;
          default: decoded.illegal = 1'b1;
        endcase
      end
      OP_JAL: begin
        decoded.imm = imm_j;
        decoded.is_jump = 1'b1;
        decoded.reg_write = 1'b1;
        decoded.wb_sel = WB_PC_PLUS_4;
      end
      default: decoded.illegal = 1'b1;
    endcase

    // illegal ops have no side effects, pc just steps by 4
    if (decoded.illegal) begin
      decoded.reg_write = 1'b0;
      decoded.mem_write = 1'b0;
      decoded.mem_read = 1'b0;
      decoded.is_branch = 1'b0;
      decoded.is_jump = 1'b0;
    end
  end

endmodule

/* logic/register_file.sv */
// register_file: 32 x 32-bit registers, x0 fixed at zero, two reads and one write
`timescale 1ns/1ps

module register_file (
  input  logic            clk,
  input  logic            rst_n,
  input  core_pkg::reg_idx rs1,
  input  core_pkg::reg_idx rs2,
  input  logic            we,
  input  core_pkg::reg_idx rd,
  input  core_pkg::word   wdata,
  output core_pkg::word   rdata1,
  output core_pkg::word   rdata2
);
  import core_pkg::*;

  word regs [32];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

/* logic/execute_unit.sv */
// execute_unit: operand muxes, ALU, branch compare and branch/jump target
`timescale 1ns/1ps

module execute_unit (
  input  core_pkg::decoded_t decoded,
  input  core_pkg::word     rdata1,
  input  core_pkg::word     rdata2,
  input  core_pkg::word     pc,
  output core_pkg::word     alu_res,
  output logic              branch_taken,
  output core_pkg::word     target
);
  import core_pkg::*;

  word op_a;
  word op_b;
  logic cmp;

  // LUI adds its immediate to zero
  assign op_a = decoded.zero_a ? '0 : rdata1;
  assign op_b = decoded.use_imm ? decoded.imm : rdata2;

  always_comb begin
    case (decoded.alu_op)
      ALU_ADD: alu_res = op_a + op_b;
      ALU_SUB: alu_res = op_a - op_b;
      ALU_AND: alu_res = op_a & op_b;
      ALU_OR:  alu_res = op_a | op_b;
      ALU_XOR: alu_res = op_a ^ op_b;
      ALU_SLT: alu_res = word'($signed(op_a) < $signed(op_b));
      default: alu_res = op_a + op_b;
    endcase
  end

  always_comb begin
    case (decoded.branch_op)
      BR_BEQ:  cmp = (rdata1 == rdata2);
      BR_BNE:  cmp = (rdata1 != rdata2);
      BR_BLT:  cmp = ($signed(rdata1) < $signed(rdata2));
      default: cmp = 1'b0;
    endcase
  end

  assign branch_taken = decoded.is_jump || (decoded.is_branch && cmp);
  assign target = pc + decoded.imm;

endmodule

/* logic/result_unit.sv */
// result_unit: data memory, write-back select, pc, retire credits and retire record
`timescale 1ns/1ps

module result_unit #(
  parameter int DMEM_WORDS = core_pkg::DMEM_WORDS_DEF,
  parameter int RETIRE_CREDITS = core_pkg::RETIRE_CREDITS_DEF,
  parameter core_pkg::word RESET_PC = core_pkg::RESET_PC_DEF
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                issue_valid,
  input  core_pkg::decoded_t  decoded,
  input  core_pkg::word       alu_res,
  input  core_pkg::word       store_data,
  input  logic                branch_taken,
  input  core_pkg::word       target,
  input  logic                retire_credit,
  output core_pkg::word       pc,
  output logic                commit,
  output logic                rf_we,
  output core_pkg::reg_idx    rf_rd,
  output core_pkg::word       rf_wdata,
  output logic                retire_valid,
  output core_pkg::retire_rec_t retire
);
  import core_pkg::*;

  localparam int ADDR_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;
  localparam int CRED_W = $clog2(RETIRE_CREDITS + 1);

  word dmem [DMEM_WORDS];
  logic [ADDR_W-1:0] dmem_idx;
  word mem_rdata;
  word pc_plus_4;
  word wb_data;
  logic misaligned;
  logic illegal;
  logic wr_reg;
  logic [CRED_W-1:0] credits;

  assign commit = issue_valid && (credits != '0);

  // word index, upper address bits alias
  assign dmem_idx = alu_res[ADDR_W+1:2];
  assign mem_rdata = dmem[dmem_idx];
  assign misaligned = (decoded.mem_read || decoded.mem_write) && (alu_res[1:0] != 2'b00);
  assign illegal = decoded.illegal || misaligned;
  assign pc_plus_4 = pc + 32'd4;

  always_comb begin
    case (decoded.wb_sel)
      WB_MEM:       wb_data = mem_rdata;
      WB_PC_PLUS_4: wb_data = pc_plus_4;
      default:      wb_data = alu_res;
    endcase
  end

  assign wr_reg = decoded.reg_write && !illegal;
  assign rf_we = commit && wr_reg;
  assign rf_rd = decoded.rd;
  assign rf_wdata = wb_data;

  always_ff @(posedge clk) begin
    if (commit && decoded.mem_write && !illegal) begin
      dmem[dmem_idx] <= store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
      credits <= CRED_W'(RETIRE_CREDITS);
      retire_valid <= 1'b0;
    end else begin
      if (commit) begin
        pc <= branch_taken ? target : pc_plus_4;
      end
      case ({commit, retire_credit})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
      retire_valid <= commit;
    end
  end

  // record payload, qualified by retire_valid
  always_ff @(posedge clk) begin
    if (commit) begin
      retire.pc <= pc;
      retire.rd <= wr_reg ? decoded.rd : '0;
      // x0 writes report zero
      retire.data <= (wr_reg && (decoded.rd != '0)) ? wb_data : '0;
      retire.reg_write <= wr_reg;
      retire.illegal <= illegal;
    end
  end

endmodule

/* logic/clic_core_top.sv */
// clic_core_top: core top level with instruction and retire credit ports
`timescale 1ns/1ps

module clic_core_top #(
  parameter int QUEUE_DEPTH = core_pkg::QUEUE_DEPTH_DEF,
  parameter int RETIRE_CREDITS = core_pkg::RETIRE_CREDITS_DEF,
  parameter int DMEM_WORDS = core_pkg::DMEM_WORDS_DEF,
  parameter core_pkg::word RESET_PC = core_pkg::RESET_PC_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid,
  input  core_pkg::word         instr,
  input  logic                  retire_credit,
  output logic                  instr_credit,
  output logic                  retire_valid,
  output core_pkg::retire_rec_t retire
);
  import core_pkg::*;

  logic head_valid;
  word head;
  logic issue_valid;
  decoded_t decoded;
  word rdata1;
  word rdata2;
  word alu_res;
  logic branch_taken;
  word target;
  word pc;
  logic commit;
  logic rf_we;
  reg_idx rf_rd;
  word rf_wdata;

  instr_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_instr_queue (
    .clk(clk),
    .rst_n(rst_n),
    .instr_valid(instr_valid),
    .instr(instr),
    .pop(commit),
    .head_valid(head_valid),
    .head(head),
    .instr_credit(instr_credit)
  );

  decode_unit u_decode (
    .head_valid(head_valid),
    .instr(head),
    .issue_valid(issue_valid),
    .decoded(decoded)
  );

  register_file u_rf (
    .clk(clk),
    .rst_n(rst_n),
    .rs1(decoded.rs1),
    .rs2(decoded.rs2),
    .we(rf_we),
    .rd(rf_rd),
    .wdata(rf_wdata),
    .rdata1(rdata1),
    .rdata2(rdata2)
  );

  execute_unit u_execute (
    .decoded(decoded),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .pc(pc),
    .alu_res(alu_res),
    .branch_taken(branch_taken),
    .target(target)
  );

  // rs2 data is the store value
  result_unit #(
    .DMEM_WORDS(DMEM_WORDS),
    .RETIRE_CREDITS(RETIRE_CREDITS),
    .RESET_PC(RESET_PC)
  ) u_result (
    .clk(clk),
    .rst_n(rst_n),
    .issue_valid(issue_valid),
    .decoded(decoded),
    .alu_res(alu_res),
    .store_data(rdata2),
    .branch_taken(branch_taken),
    .target(target),
    .retire_credit(retire_credit),
    .pc(pc),
    .commit(commit),
    .rf_we(rf_we),
    .rf_rd(rf_rd),
    .rf_wdata(rf_wdata),
    .retire_valid(retire_valid),
    .retire(retire)
  );

endmodule

/* dv/clic_core_checker.sv */
// clic_core_checker: assertions on queue fill, retire credits and reset state, bound to the top
`timescale 1ns/1ps

module clic_core_checker #(
  parameter int QUEUE_DEPTH = core_pkg::QUEUE_DEPTH_DEF,
  parameter int RETIRE_CREDITS = core_pkg::RETIRE_CREDITS_DEF
) (
  input logic clk,
  input logic rst_n,
  input logic instr_valid,
  input logic commit,
  input logic instr_credit,
  input logic retire_valid,
  input logic retire_credit
);
  int occupancy;
  int outstanding;

  // queue fill and records still waiting for a credit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occupancy <= 0;
      outstanding <= 0;
    end else begin
      occupancy <= occupancy + int'(instr_valid) - int'(commit);
      outstanding <= outstanding + int'(retire_valid) - int'(retire_credit);
    end
  end

  retire_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> outstanding < RETIRE_CREDITS)
    else $error("retire record presented without a credit");

  no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid |-> occupancy < QUEUE_DEPTH)
    else $error("instruction pushed into a full queue");

  quiet_in_reset: assert property (@(posedge clk)
    !rst_n |=> (!retire_valid && !instr_credit))
    else $error("retire_valid or instr_credit high during reset");

endmodule

bind clic_core_top clic_core_checker #(
  .QUEUE_DEPTH(QUEUE_DEPTH),
  .RETIRE_CREDITS(RETIRE_CREDITS)
) u_checker (
  .clk(clk),
  .rst_n(rst_n),
  .instr_valid(instr_valid),
  .commit(commit),
  .instr_credit(instr_credit),
  .retire_valid(retire_valid),
  .retire_credit(retire_credit)
);

/* dv/clic_core_tb.sv */
// trace-driven testbench for clic_core_top with credit handshakes, retire checks and watchdog
`timescale 1ns/1ps

module clic_core_tb;
  import core_pkg::*;

  localparam int QUEUE_DEPTH = QUEUE_DEPTH_DEF;
  localparam int RETIRE_CREDITS = RETIRE_CREDITS_DEF;
  localparam int DMEM_WORDS = DMEM_WORDS_DEF;
  localparam word RESET_PC = RESET_PC_DEF;
  localparam int CYCLES_PER_INSTR = 40;

  logic clk;
  logic rst_n;
  logic instr_valid;
  word instr;
  logic retire_credit;
  logic instr_credit;
  logic retire_valid;
  retire_rec_t retire;

  word instr_q[$];
  retire_rec_t exp_q[$];
  string name_q[$];
  int rec_total;
  int matched;
  int instr_credits;
  int owed_credits;
  int drain;
  bit trace_loaded;

  clic_core_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .RETIRE_CREDITS(RETIRE_CREDITS),
    .DMEM_WORDS(DMEM_WORDS),
    .RESET_PC(RESET_PC)
  ) dut_i (
    .clk(clk),
    .rst_n(rst_n),
    .instr_valid(instr_valid),
    .instr(instr),
    .retire_credit(retire_credit),
    .instr_credit(instr_credit),
    .retire_valid(retire_valid),
    .retire(retire)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic string format_record(retire_rec_t r);
    return $sformatf("pc=%h rd=%0d data=%h we=%b ill=%b", r.pc, r.rd, r.data, r.reg_write,
                     r.illegal);
  endfunction

  task automatic check_retire(string test, retire_rec_t expected, retire_rec_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %s actual %s", test, format_record(expected),
               format_record(actual));
      abort_run();
    end
  endtask

  // each trace line holds an instruction word and the record it must retire with
  task automatic load_trace();
    int fd;
    int fields;
    string line;
    string tag;
    string name;
    word iw;
    word rpc;
    word rdata;
    reg_idx rrd;
    logic rwe;
    logic rill;
    retire_rec_t rec;
    fd = $fopen("dv/program_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file dv/program_trace.txt");
      abort_run();
    end else begin
      name = "none";
      while (!$feof(fd)) begin
        line = "";
        fields = $fgets(line, fd);
        if (fields > 0 && $sscanf(line, "%s", tag) == 1 && tag.getc(0) != "#") begin
          if (tag == "test") begin
            fields = $sscanf(line, "%s %s", tag, name);
          end else begin
            fields = $sscanf(line, "%h %h %h %h %h %h", iw, rpc, rrd, rdata, rwe, rill);
            if (fields != 6) begin
              $display("malformed trace line: %s", line);
              abort_run();
            end else begin
              rec.pc = rpc;
              rec.rd = rrd;
              rec.data = rdata;
              rec.reg_write = rwe;
              rec.illegal = rill;
              instr_q.push_back(iw);
              exp_q.push_back(rec);
              name_q.push_back(name);
            end
          end
        end
      end
      $fclose(fd);
      rec_total = exp_q.size();
      if (rec_total == 0) begin
        $display("trace file holds no instructions");
        abort_run();
      end else begin
        trace_loaded = 1'b1;
      end
    end
  endtask

  // sample outputs and then drive the next inputs
  task automatic run_cycle();
    retire_rec_t exp_rec;
    string test;
    if (retire_valid) begin
      if (exp_q.size() == 0) begin
        $display("extra retire record after the last expected one: %s", format_record(retire));
        abort_run();
      end else begin
        exp_rec = exp_q.pop_front();
        test = name_q.pop_front();
        check_retire(test, exp_rec, retire);
        matched++;
        owed_credits++;
      end
    end
    if (instr_credit) begin
      instr_credits++;
    end
    if (instr_credits > QUEUE_DEPTH) begin
      $display("core returned more instruction credits than were spent");
      abort_run();
    end else begin
      // withhold retire credits about half the time
      if (owed_credits > 0 && ($urandom % 32'd4) < 32'd2) begin
        retire_credit = 1'b1;
        owed_credits--;
      end else begin
        retire_credit = 1'b0;
      end
      if (instr_credits > 0 && instr_q.size() > 0) begin
        instr_valid = 1'b1;
        instr = instr_q.pop_front();
        instr_credits--;
      end else begin
        instr_valid = 1'b0;
        instr = '0;
      end
    end
  endtask

  initial begin
    void'($urandom(32'h4369));
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    retire_credit = 1'b0;
    matched = 0;
    instr_credits = QUEUE_DEPTH;
    owed_credits = 0;
    drain = 0;
    trace_loaded = 1'b0;
    load_trace();
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
    // a few idle cycles at the end catch duplicated records
    while (matched < rec_total || drain < 10) begin
      @(posedge clk);
      #10;
      run_cycle();
      if (matched == rec_total) begin
        drain++;
      end
    end
    $display("All checks passed");
    $finish;
  end

  initial begin
    wait (trace_loaded);
    repeat (rec_total * CYCLES_PER_INSTR + 4) @(posedge clk);
    $display("watchdog expired, core stalled with %0d of %0d records retired", matched,
             rec_total);
    abort_run();
  end

endmodule

/* dv/program_trace.txt */
# columns: instr pc rd data reg_write illegal (hex), one line per executed instruction
# a line starting with test names the group that follows
test alu_ops
00500093 00000000 01 00000005 1 0
ffd00113 00000004 02 fffffffd 1 0
002081b3 00000008 03 00000002 1 0
40208233 0000000c 04 00000008 1 0
0020f2b3 00000010 05 00000005 1 0
0020e333 00000014 06 fffffffd 1 0
0020c3b3 00000018 07 fffffff8 1 0
00112433 0000001c 08 00000001 1 0
0020a4b3 00000020 09 00000000 1 0
00108033 00000024 00 00000000 1 0
test lui_mem
12345537 00000028 0a 12345000 1 0
67850513 0000002c 0a 12345678 1 0
00a02823 00000030 00 00000000 0 0
01002583 00000034 0b 12345678 1 0
fe20afa3 00000038 00 00000000 0 0
00402603 0000003c 0c fffffffd 1 0
test branches
00108463 00000040 00 00000000 0 0
00109463 00000048 00 00000000 0 0
00114663 0000004c 00 00000000 0 0
0020c463 00000058 00 00000000 0 0
fe209ce3 0000005c 00 00000000 0 0
010006ef 00000054 0d 00000058 1 0
ff9ff06f 00000064 00 00000000 1 0
test illegal
00000000 0000005c 00 00000000 0 1
00109733 00000060 00 00000000 0 1
0010a783 00000064 00 00000000 0 1
002028a3 00000068 00 00000000 0 1
01002803 0000006c 10 12345678 1 0
00f708b3 00000070 11 00000000 1 0
test stream
00190913 00000074 12 00000001 1 0
00190913 00000078 12 00000002 1 0
00190913 0000007c 12 00000003 1 0
00190913 00000080 12 00000004 1 0
00190913 00000084 12 00000005 1 0

/* filelist.f */
logic/core_pkg.sv
logic/instr_queue.sv
logic/decode_unit.sv
logic/register_file.sv
logic/execute_unit.sv
logic/result_unit.sv
logic/clic_core_top.sv
dv/clic_core_checker.sv
dv/clic_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module clic_core_tb \
  --Mdir obj_dir -o clic_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/clic_core_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
